// File: Makefile
# Verilator build for the FC8 system core

VERILATOR    ?= verilator
TOP          ?= fc8_system_tb
FRAME_CYCLES ?= 1000
LOG          ?= sim.log
OBJ_DIR      ?= obj_dir

FILELIST := fc8_system.f
SOURCES  := $(shell cat $(FILELIST))
BINARY   := $(OBJ_DIR)/V$(TOP)
PASS_MSG := all tests passed

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -GFRAME_CYCLES=$(FRAME_CYCLES) \
		--Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)

run: compile
	./$(BINARY) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: fc8_system.f
source/fc8_pkg.sv
source/fc8_frame_timer.sv
source/fc8_interrupt_controller.sv
source/fc8_sfr_block.sv
source/fc8_ram.sv
source/fc8_mmu.sv
source/fc8_system.sv
tb/fc8_system_tb.sv

// File: source/fc8_frame_timer.sv
// FC8 frame timer
`timescale 1ns/100ps
`default_nettype none

module fc8_frame_timer #(
    parameter int FRAME_CYCLES = 1000
) (
    input  wire   master_clk,
    input  wire   master_rst_n,
    output logic  new_frame
);

    localparam int CNT_W = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;

    logic [CNT_W-1:0] frame_cnt;
    logic             frame_end;

    assign frame_end = (frame_cnt == CNT_W'(FRAME_CYCLES - 1));

    always_ff @(posedge master_clk or negedge master_rst_n) begin
        if (!master_rst_n) begin
            frame_cnt <= '0;
            new_frame <= 1'b0;
        end else begin
            new_frame <= frame_end;     // Vertical blank starts here
            if (frame_end) begin
                frame_cnt <= '0;
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    a_single_pulse: assert property (
        @(posedge master_clk) disable iff (!master_rst_n)
        new_frame |=> !new_frame);

endmodule

`default_nettype wire

// File: source/fc8_interrupt_controller.sv
// FC8 interrupt controller
`timescale 1ns/100ps
`default_nettype none

module fc8_interrupt_controller import fc8_pkg::*; (
    input  wire         master_clk,
    input  wire         master_rst_n,
    input  wire         new_frame,
    input  wire [1:0]   int_enable,
    input  wire         timer_enable,
    input  prescaler_t  timer_prescale,
    input  wire [1:0]   clear_pending,
    output logic [1:0]  pending,
    output logic        nmi_req,
    output logic        irq_req
);

    // Wide enough for the longest period, 2**(PRESCALE_BASE + 15)
    localparam int TIMER_W = PRESCALE_BASE + 2 ** $bits(prescaler_t);

    logic [TIMER_W-1:0] timer_cnt;
    logic [TIMER_W-1:0] period_last;
    prescaler_t         prescale_q;     // Select seen last cycle
    logic               timer_tick;
    logic [1:0]         event_set;

    assign period_last = (TIMER_W'(1) << (PRESCALE_BASE + timer_prescale)) - TIMER_W'(1);
    assign timer_tick  = timer_enable && (timer_prescale == prescale_q) &&
                         (timer_cnt == period_last);

    always_ff @(posedge master_clk or negedge master_rst_n) begin
        if (!master_rst_n) begin
            timer_cnt  <= '0;
            prescale_q <= '0;
        end else begin
            prescale_q <= timer_prescale;
            if (!timer_enable || timer_prescale != prescale_q || timer_tick) begin
                timer_cnt <= '0;    // Restart on disable, new select or wrap
            end else begin
                timer_cnt <= timer_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        event_set                 = '0;
        event_set[INT_BIT_VBLANK] = new_frame;
        event_set[INT_BIT_TIMER]  = timer_tick;
    end

    // Sticky flags, a new event beats a clear in the same cycle
    always_ff @(posedge master_clk or negedge master_rst_n) begin
        if (!master_rst_n) begin
            pending <= '0;
        end else begin
            pending <= event_set | (pending & ~clear_pending);
        end
    end

    assign nmi_req = pending[INT_BIT_VBLANK] & int_enable[INT_BIT_VBLANK];
    assign irq_req = pending[INT_BIT_TIMER]  & int_enable[INT_BIT_TIMER];

    a_nmi_gated: assert property (
        @(posedge master_clk) disable iff (!master_rst_n)
        nmi_req |-> int_enable[INT_BIT_VBLANK]);

    a_irq_gated: assert property (
        @(posedge master_clk) disable iff (!master_rst_n)
        irq_req |-> int_enable[INT_BIT_TIMER]);

endmodule

`default_nettype wire

// File: source/fc8_mmu.sv
// FC8 address decoder
`timescale 1ns/100ps
`default_nettype none

module fc8_mmu import fc8_pkg::*; #(
    parameter int RAM_ADDR_W = 10
) (
    input  wire                    master_clk,
    input  wire                    master_rst_n,
    input  addr_t                  addr,
    input  byte_t                  wdata,
    input  wire                    rd_en,
    input  wire                    wr_en,
    output byte_t                  rdata,
    output logic [RAM_ADDR_W-1:0]  ram_addr,
    output byte_t                  ram_wdata,
    output logic                   ram_wr,
    output logic                   ram_rd,
    input  byte_t                  ram_rdata,
    output sfr_offset_t            sfr_offset,
    output byte_t                  sfr_wdata,
    output logic                   sfr_wr,
    output logic                   sfr_rd,
    input  byte_t                  sfr_rdata
);

    typedef enum logic [1:0] {
        SRC_OPEN,
        SRC_RAM,
        SRC_SFR
    } rd_src_t;

    logic    in_ram;
    logic    in_sfr;
    addr_t   ram_rel;
    addr_t   sfr_rel;
    rd_src_t rd_src;
    logic    rd_pending;    // Read data arrives from the source this cycle
    byte_t   rd_mux;

    // Unsigned offset compare covers both ends of a region
    function automatic logic in_range(addr_t a, addr_t base, addr_t limit);
        return addr_t'(a - base) <= addr_t'(limit - base);
    endfunction

    assign in_ram  = in_range(addr, RAM_BASE, RAM_LIMIT);
    assign in_sfr  = in_range(addr, SFR_BASE, SFR_LIMIT);
    assign ram_rel = addr - RAM_BASE;
    assign sfr_rel = addr - SFR_BASE;

    assign ram_addr   = ram_rel[RAM_ADDR_W-1:0];    // Upper bits ignored, RAM mirrors
    assign ram_wdata  = wdata;
    assign ram_wr     = wr_en & in_ram;
    assign ram_rd     = rd_en & in_ram;

    assign sfr_offset = sfr_offset_t'(sfr_rel);
    assign sfr_wdata  = wdata;
    assign sfr_wr     = wr_en & in_sfr;
    assign sfr_rd     = rd_en & in_sfr;

    always_comb begin
        case (rd_src)
            SRC_RAM: rd_mux = ram_rdata;
            SRC_SFR: rd_mux = sfr_rdata;
            default: rd_mux = OPEN_BUS_VALUE;
        endcase
    end

    always_ff @(posedge master_clk or negedge master_rst_n) begin
        if (!master_rst_n) begin
            rd_src     <= SRC_OPEN;
            rd_pending <= 1'b0;
            rdata      <= '0;
        end else begin
            rd_pending <= rd_en;
            if (rd_en) begin
                rd_src <= in_ram ? SRC_RAM : (in_sfr ? SRC_SFR : SRC_OPEN);
            end
            if (rd_pending) rdata <= rd_mux;    // Held until the next read completes
        end
    end

    a_no_rd_wr_overlap: assert property (
        @(posedge master_clk) disable iff (!master_rst_n) !(rd_en && wr_en));

    a_one_target: assert property (
        @(posedge master_clk) disable iff (!master_rst_n)
        !((ram_rd || ram_wr) && (sfr_rd || sfr_wr)));

endmodule

`default_nettype wire

// File: source/fc8_pkg.sv
// FC8 system definitions
`default_nettype none

package fc8_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;

    // Low address byte inside the SFR window
    typedef logic [7:0]  sfr_offset_t;

    // Timer prescale select, bits 3..0 of the timer control register
    typedef logic [3:0]  prescaler_t;

    // Memory map
    localparam addr_t RAM_BASE  = 16'h0000;
    localparam addr_t RAM_LIMIT = 16'h7FFF;
    localparam addr_t SFR_BASE  = 16'h8000;
    localparam addr_t SFR_LIMIT = 16'h80FF;

    localparam byte_t OPEN_BUS_VALUE = 8'hFF;   // Pulled-up data bus

    // SFR offsets
    localparam sfr_offset_t SFR_INT_ENABLE     = 8'h00;
    localparam sfr_offset_t SFR_INT_STATUS     = 8'h01;
    localparam sfr_offset_t SFR_TIMER_CTRL     = 8'h02;
    localparam sfr_offset_t SFR_GAMEPAD1       = 8'h03;
    localparam sfr_offset_t SFR_GAMEPAD2       = 8'h04;
    localparam sfr_offset_t SFR_GAMEPAD_STATUS = 8'h05;
    localparam sfr_offset_t SFR_FRAME_COUNT    = 8'h06;

    // Bit positions in the enable and status registers
    localparam int INT_BIT_VBLANK = 0;
    localparam int INT_BIT_TIMER  = 1;

    localparam int TIMER_ENABLE_BIT = 7;

    // Timer period is 2**(PRESCALE_BASE + select) cycles
    localparam int PRESCALE_BASE = 4;

endpackage

`default_nettype wire

// File: source/fc8_ram.sv
// FC8 work RAM
`timescale 1ns/100ps
`default_nettype none

module fc8_ram import fc8_pkg::*; #(
    parameter int RAM_ADDR_W = 10
) (
    input  wire                   master_clk,
    input  wire [RAM_ADDR_W-1:0]  ram_addr,
    input  byte_t                 ram_wdata,
    input  wire                   ram_wr,
    input  wire                   ram_rd,
    output byte_t                 ram_rdata
);

    localparam int DEPTH = 2 ** RAM_ADDR_W;

    byte_t mem [DEPTH];

    always_ff @(posedge master_clk) begin
        if (ram_wr) begin
            mem[ram_addr] <= ram_wdata;
        end
    end

    // Read port, data held between reads
    always_ff @(posedge master_clk) begin
        if (ram_rd) begin
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

`default_nettype wire

// File: source/fc8_sfr_block.sv
// FC8 special function registers
`timescale 1ns/100ps
`default_nettype none

module fc8_sfr_block import fc8_pkg::*; (
    input  wire          master_clk,
    input  wire          master_rst_n,
    input  sfr_offset_t  sfr_offset,
    input  byte_t        sfr_wdata,
    input  wire          sfr_wr,
    input  wire          sfr_rd,
    output byte_t        sfr_rdata,
    input  byte_t        gamepad1_data,
    input  byte_t        gamepad2_data,
    input  wire          gamepad1_connected,
    input  wire          gamepad2_connected,
    input  wire [1:0]    pending,
    input  wire          new_frame,
    output logic [1:0]   int_enable,
    output logic         timer_enable,
    output prescaler_t   timer_prescale,
    output logic [1:0]   clear_pending
);

    byte_t frame_count;
    byte_t rd_value;

    // Write-one-to-clear, active in the strobe cycle
    always_comb begin
        clear_pending = '0;
        if (sfr_wr && sfr_offset == SFR_INT_STATUS) begin
            clear_pending[INT_BIT_VBLANK] = sfr_wdata[INT_BIT_VBLANK];
            clear_pending[INT_BIT_TIMER]  = sfr_wdata[INT_BIT_TIMER];
        end
    end

    always_ff @(posedge master_clk or negedge master_rst_n) begin
        if (!master_rst_n) begin
            int_enable     <= '0;
            timer_enable   <= 1'b0;
            timer_prescale <= '0;
        end else if (sfr_wr) begin
            case (sfr_offset)
                SFR_INT_ENABLE: begin
                    int_enable[INT_BIT_VBLANK] <= sfr_wdata[INT_BIT_VBLANK];
                    int_enable[INT_BIT_TIMER]  <= sfr_wdata[INT_BIT_TIMER];
                end
                SFR_TIMER_CTRL: begin
                    timer_enable   <= sfr_wdata[TIMER_ENABLE_BIT];
                    timer_prescale <= sfr_wdata[$bits(prescaler_t)-1:0];
                end
                default: ;  // Other offsets are read-only or unused
            endcase
        end
    end

    // Counts vertical blanks, wraps at 256
    always_ff @(posedge master_clk or negedge master_rst_n) begin
        if (!master_rst_n) begin
            frame_count <= '0;
        end else if (new_frame) begin
            frame_count <= frame_count + 1'b1;
        end
    end

    always_comb begin
        rd_value = '0;
        case (sfr_offset)
            SFR_INT_ENABLE:     rd_value[1:0] = int_enable;
            SFR_INT_STATUS:     rd_value[1:0] = pending;
            SFR_TIMER_CTRL: begin
                rd_value[TIMER_ENABLE_BIT]        = timer_enable;
                rd_value[$bits(prescaler_t)-1:0] = timer_prescale;
            end
            SFR_GAMEPAD1:       rd_value = gamepad1_connected ? gamepad1_data : '0;
            SFR_GAMEPAD2:       rd_value = gamepad2_connected ? gamepad2_data : '0;
            SFR_GAMEPAD_STATUS: rd_value[1:0] = {gamepad2_connected, gamepad1_connected};
            SFR_FRAME_COUNT:    rd_value = frame_count;
            default:            rd_value = '0;
        endcase
    end

    always_ff @(posedge master_clk) begin
        if (sfr_rd) sfr_rdata <= rd_value;  // One cycle read latency
    end

endmodule

`default_nettype wire

// File: source/fc8_system.sv
// FC8 system core
`timescale 1ns/100ps
`default_nettype none

module fc8_system import fc8_pkg::*; #(
    parameter int RAM_ADDR_W   = 10,
    parameter int FRAME_CYCLES = 1000
) (
    input  wire    master_clk,
    input  wire    master_rst_n,
    // External bus master
    input  addr_t  addr,
    input  byte_t  wdata,
    input  wire    rd_en,
    input  wire    wr_en,
    output byte_t  rdata,
    // Gamepad ports
    input  byte_t  gamepad1_data,
    input  byte_t  gamepad2_data,
    input  wire    gamepad1_connected,
    input  wire    gamepad2_connected,
    output logic   nmi_req,
    output logic   irq_req
);

    logic [RAM_ADDR_W-1:0] ram_addr;
    byte_t                 ram_wdata;
    byte_t                 ram_rdata;
    logic                  ram_wr;
    logic                  ram_rd;

    sfr_offset_t           sfr_offset;
    byte_t                 sfr_wdata;
    byte_t                 sfr_rdata;
    logic                  sfr_wr;
    logic                  sfr_rd;

    logic [1:0]            int_enable;
    logic                  timer_enable;
    prescaler_t            timer_prescale;
    logic [1:0]            clear_pending;
    logic [1:0]            pending;
    logic                  new_frame;

    fc8_mmu #(.RAM_ADDR_W(RAM_ADDR_W)) u_mmu (
        .master_clk, .master_rst_n,
        .addr, .wdata, .rd_en, .wr_en, .rdata,
        .ram_addr, .ram_wdata, .ram_wr, .ram_rd, .ram_rdata,
        .sfr_offset, .sfr_wdata, .sfr_wr, .sfr_rd, .sfr_rdata
    );

    fc8_ram #(.RAM_ADDR_W(RAM_ADDR_W)) u_ram (
        .master_clk,
        .ram_addr, .ram_wdata, .ram_wr, .ram_rd, .ram_rdata
    );

    fc8_sfr_block u_sfr_block (
        .master_clk, .master_rst_n,
        .sfr_offset, .sfr_wdata, .sfr_wr, .sfr_rd, .sfr_rdata,
        .gamepad1_data, .gamepad2_data, .gamepad1_connected, .gamepad2_connected,
        .pending, .new_frame,
        .int_enable, .timer_enable, .timer_prescale, .clear_pending
    );

    fc8_interrupt_controller u_interrupt_controller (
        .master_clk, .master_rst_n,
        .new_frame, .int_enable, .timer_enable, .timer_prescale, .clear_pending,
        .pending, .nmi_req, .irq_req
    );

    fc8_frame_timer #(.FRAME_CYCLES(FRAME_CYCLES)) u_frame_timer (
        .master_clk, .master_rst_n,
        .new_frame
    );

endmodule

`default_nettype wire

// File: tb/fc8_system_tb.sv
// FC8 system testbench
`timescale 1ns/100ps
`default_nettype none

module fc8_system_tb import fc8_pkg::*; #(
    parameter int FRAME_CYCLES = 1000
);

    localparam int RAM_ADDR_W = 10;
    localparam int CLK_HALF   = 20;    // 40 ns period

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_READ_MIN, OP_WAIT, OP_WAIT_NMI, OP_WAIT_IRQ, OP_GAMEPAD
    } op_t;

    // addr doubles as cycle bound for waits and pad number for gamepad steps
    typedef struct packed {
        op_t   op;
        addr_t addr;
        byte_t data;
        byte_t exp;
    } step_t;

    logic  master_clk;
    logic  master_rst_n;
    addr_t addr;
    byte_t wdata;
    logic  rd_en;
    logic  wr_en;
    byte_t rdata;
    byte_t gamepad1_data;
    byte_t gamepad2_data;
    logic  gamepad1_connected;
    logic  gamepad2_connected;
    logic  nmi_req;
    logic  irq_req;

    step_t       steps[$];
    logic [31:0] rng_state;
    int          mismatch_count;
    int          wait_fail_count;
    logic        table_ready;

    fc8_system #(.RAM_ADDR_W(RAM_ADDR_W), .FRAME_CYCLES(FRAME_CYCLES)) i_dut (.*);

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic addr_t sfr_addr(sfr_offset_t offset);
        return SFR_BASE + addr_t'(offset);
    endfunction

    function automatic void add_step(op_t op, addr_t a, byte_t d, byte_t e);
        step_t s;
        s.op   = op;
        s.addr = a;
        s.data = d;
        s.exp  = e;
        steps.push_back(s);
    endfunction

    task automatic check_byte(string name, byte_t expected, byte_t actual, bit at_least);
        if ($isunknown(actual) || (at_least ? (actual < expected) : (actual != expected))) begin
            mismatch_count++;
            $display("FAIL at time %0t: %s expected %s0x%02h, got 0x%02h", $time, name,
                     at_least ? ">= " : "", expected, actual);
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("FAIL at time %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic report_counts();
        $display("Error count: %0d value mismatches, %0d wait failures",
                 mismatch_count, wait_fail_count);
    endtask

    task automatic build_table();
        addr_t ram_addrs [6] = '{16'h0000, 16'h0001, 16'h0100, 16'h0155, 16'h02AA, 16'h03FF};
        byte_t ram_bytes [6];
        byte_t vblank_en;
        byte_t timer_en;
        vblank_en = byte_t'(1 << INT_BIT_VBLANK);
        timer_en  = byte_t'(1 << INT_BIT_TIMER);
        // Reset values
        add_step(OP_WAIT_NMI, 16'd0, 8'h00, 8'h00);
        add_step(OP_WAIT_IRQ, 16'd0, 8'h00, 8'h00);
        add_step(OP_READ, sfr_addr(SFR_INT_ENABLE), 8'h00, 8'h00);
        add_step(OP_READ, sfr_addr(SFR_INT_STATUS), 8'h00, 8'h00);
        add_step(OP_READ, sfr_addr(SFR_FRAME_COUNT), 8'h00, 8'h00);
        // Random bytes into RAM and mirrored reads back
        foreach (ram_addrs[i]) begin
            rng_state    = xorshift32(rng_state);
            ram_bytes[i] = rng_state[7:0];
            add_step(OP_WRITE, ram_addrs[i], ram_bytes[i], 8'h00);
        end
        foreach (ram_addrs[i]) add_step(OP_READ, ram_addrs[i], 8'h00, ram_bytes[i]);
        add_step(OP_READ, ram_addrs[3] + addr_t'(2 ** RAM_ADDR_W), 8'h00, ram_bytes[3]);
        add_step(OP_READ, 16'h7C00 | ram_addrs[5], 8'h00, ram_bytes[5]);  // Top of region
        // Unmapped reads and writes
        add_step(OP_READ, 16'h8100, 8'h00, OPEN_BUS_VALUE);
        add_step(OP_READ, 16'hC000, 8'h00, OPEN_BUS_VALUE);
        add_step(OP_WRITE, 16'h8100, 8'h03, 8'h00);
        add_step(OP_WRITE, 16'hC000, ~ram_bytes[0], 8'h00);
        add_step(OP_READ, sfr_addr(SFR_INT_ENABLE), 8'h00, 8'h00);
        add_step(OP_READ, 16'h0000, 8'h00, ram_bytes[0]);
        add_step(OP_READ, 16'h0100, 8'h00, ram_bytes[2]);
        // Gamepads with the connect flag in exp[0]
        add_step(OP_GAMEPAD, 16'd1, 8'h5A, 8'h01);
        add_step(OP_GAMEPAD, 16'd2, 8'hC3, 8'h01);
        add_step(OP_READ, sfr_addr(SFR_GAMEPAD1), 8'h00, 8'h5A);
        add_step(OP_READ, sfr_addr(SFR_GAMEPAD2), 8'h00, 8'hC3);
        add_step(OP_READ, sfr_addr(SFR_GAMEPAD_STATUS), 8'h00, 8'h03);
        add_step(OP_GAMEPAD, 16'd2, 8'hC3, 8'h00);
        add_step(OP_READ, sfr_addr(SFR_GAMEPAD2), 8'h00, 8'h00);
        add_step(OP_READ, sfr_addr(SFR_GAMEPAD_STATUS), 8'h00, 8'h01);
        add_step(OP_READ, sfr_addr(SFR_GAMEPAD1), 8'h00, 8'h5A);
        // Vertical blank and NMI
        add_step(OP_WRITE, sfr_addr(SFR_INT_STATUS), vblank_en, 8'h00);
        add_step(OP_WRITE, sfr_addr(SFR_INT_ENABLE), vblank_en, 8'h00);
        add_step(OP_WAIT_NMI, addr_t'(FRAME_CYCLES + 2), 8'h01, 8'h00);
        add_step(OP_READ_MIN, sfr_addr(SFR_FRAME_COUNT), 8'h00, 8'h01);
        add_step(OP_WRITE, sfr_addr(SFR_INT_STATUS), vblank_en, 8'h00);
        add_step(OP_WAIT_NMI, 16'd1, 8'h00, 8'h00);
        // Timer and IRQ at prescale select 0
        add_step(OP_WRITE, sfr_addr(SFR_INT_ENABLE), timer_en, 8'h00);
        add_step(OP_WRITE, sfr_addr(SFR_TIMER_CTRL), byte_t'(1 << TIMER_ENABLE_BIT), 8'h00);
        add_step(OP_WAIT_IRQ, addr_t'(2 ** PRESCALE_BASE + 2), 8'h01, 8'h00);
        add_step(OP_WRITE, sfr_addr(SFR_TIMER_CTRL), 8'h00, 8'h00);
        add_step(OP_WRITE, sfr_addr(SFR_INT_STATUS), timer_en, 8'h00);
        add_step(OP_WAIT, 16'd64, 8'h02, 8'h00);    // IRQ must stay low
        add_step(OP_READ, sfr_addr(SFR_TIMER_CTRL), 8'h00, 8'h00);
    endtask

    task automatic run_step(step_t s);
        int   cyc;
        logic level;
        case (s.op)
            OP_WRITE: begin
                addr  = s.addr;
                wdata = s.data;
                wr_en = 1'b1;
                @(negedge master_clk);
                wr_en = 1'b0;
            end
            OP_READ, OP_READ_MIN: begin
                addr  = s.addr;
                rd_en = 1'b1;
                @(negedge master_clk);
                rd_en = 1'b0;
                @(negedge master_clk);  // Data valid after the following edge
                check_byte($sformatf("rdata (addr 0x%04h)", s.addr), s.exp, rdata,
                           s.op == OP_READ_MIN);
            end
            OP_WAIT: begin
                repeat (int'(s.addr)) begin
                    @(negedge master_clk);
                    if (s.data[0]) check_bit("nmi_req", s.exp[0], nmi_req);
                    if (s.data[1]) check_bit("irq_req", s.exp[1], irq_req);
                end
            end
            OP_WAIT_NMI, OP_WAIT_IRQ: begin
                cyc   = 0;
                level = (s.op == OP_WAIT_NMI) ? nmi_req : irq_req;
                while (level !== s.data[0] && cyc < int'(s.addr)) begin
                    @(negedge master_clk);
                    cyc++;
                    level = (s.op == OP_WAIT_NMI) ? nmi_req : irq_req;
                end
                if (s.addr == 16'd0) begin
                    check_bit(s.op == OP_WAIT_NMI ? "nmi_req" : "irq_req", s.data[0], level);
                end else if (level !== s.data[0]) begin
                    wait_fail_count++;
                    $display("Waited %0d cycles but %s never went to %b", cyc,
                             s.op == OP_WAIT_NMI ? "nmi_req" : "irq_req", s.data[0]);
                end
            end
            OP_GAMEPAD: begin
                if (s.addr == 16'd1) begin
                    gamepad1_data      = s.data;
                    gamepad1_connected = s.exp[0];
                end else begin
                    gamepad2_data      = s.data;
                    gamepad2_connected = s.exp[0];
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        master_clk = 1'b0;
        forever #(CLK_HALF) master_clk = ~master_clk;
    end

    initial begin
        table_ready        = 1'b0;
        master_rst_n       = 1'b0;
        addr               = '0;
        wdata              = '0;
        rd_en              = 1'b0;
        wr_en              = 1'b0;
        gamepad1_data      = '0;
        gamepad2_data      = '0;
        gamepad1_connected = 1'b0;
        gamepad2_connected = 1'b0;
        mismatch_count     = 0;
        wait_fail_count    = 0;
        rng_state          = 32'hc000_4b27;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(negedge master_clk);
        master_rst_n = 1'b1;
        check_byte("rdata", 8'h00, rdata, 1'b0);
        foreach (steps[i]) run_step(steps[i]);
        repeat (2) @(negedge master_clk);
        report_counts();
        if (mismatch_count == 0 && wait_fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Bound covers the slowest timer period per step plus a few frames
    initial begin
        longint limit;
        wait (table_ready);
        limit = longint'(steps.size()) * (longint'(1) << (PRESCALE_BASE + 15))
              + 4 * longint'(FRAME_CYCLES);
        repeat (limit) @(posedge master_clk);
        $display("Watchdog expired after %0d cycles before the test table finished", limit);
        report_counts();
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
